// File: filelist.f
source/link_pkg.sv
source/regfile_pkg.sv
source/link_decoder.sv
source/register_block.sv
source/reply_builder.sv
source/register_link.sv
sim/tb_register_link.sv

// File: run_sim.sh
#!/bin/sh
# build and run the register link testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_register_link

verilator --binary --assert --timescale 1ns/1ps \
	--top-module "$TOP" \
	-f filelist.f \
	-Mdir "$BUILD_DIR" \
	-o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the testbench output
if grep -q "RESULT: PASS" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// File: sim/tb_register_link.sv
`timescale 1ns/1ps

module tb_register_link;

	logic clk = 1'b0;
	logic reset;
	logic [link_pkg::WORD_W-1:0] rx_data;
	logic rx_valid;
	link_pkg::reply_t tx;
	logic illegal_reg_num;

	integer seed;
	int cyc = 0; // falling edges seen so far
	int checks = 0;
	int value_errs = 0;
	int other_errs = 0;

	// reference state, kept in step with every word sent
	logic [regfile_pkg::REG_W-1:0] model_regs [regfile_pkg::NUM_REGS];
	logic [regfile_pkg::REG_W-1:0] model_num;
	link_pkg::op_t model_pend; // OP_NOP while a header is expected

	// expected replies in the order of their headers
	link_pkg::reply_t exp_q[$];
	int due_q[$];
	string name_q[$];

	register_link dut0 (
		.clk            (clk),
		.reset          (reset),
		.rx_data        (rx_data),
		.rx_valid       (rx_valid),
		.tx             (tx),
		.illegal_reg_num(illegal_reg_num)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	function automatic logic model_illegal();
		return model_num >= regfile_pkg::NUM_REGS;
	endfunction

	// reserved bits get junk, the decoder must ignore them
	function automatic logic [31:0] header_word(input logic [3:0] op);
		logic [31:0] junk;
		junk = rnd();
		return {op, junk[27:0]};
	endfunction

	// advance the model by one word, returns the reply it calls for
	function automatic link_pkg::reply_t predict_reply(input logic [31:0] word);
		link_pkg::reply_t r;
		logic [3:0] op;
		r = '0;
		op = word[31:28];
		if (model_pend == link_pkg::OP_SELECT) begin
			model_num = word;
			model_pend = link_pkg::OP_NOP;
		end else if (model_pend == link_pkg::OP_WRITE) begin
			if (!model_illegal())
				model_regs[model_num[3:0]] = word;
			model_pend = link_pkg::OP_NOP;
		end else begin
			case (op)
				link_pkg::OP_NOP: begin
				end
				link_pkg::OP_SELECT: model_pend = link_pkg::OP_SELECT;
				link_pkg::OP_WRITE: model_pend = link_pkg::OP_WRITE;
				link_pkg::OP_READ: begin
					r.valid = 1'b1;
					r.error = model_illegal();
					r.data = model_illegal() ? '0 : model_regs[model_num[3:0]];
				end
				default: begin
					r.valid = 1'b1;
					r.error = 1'b1;
				end
			endcase
		end
		return r;
	endfunction

	task automatic check_reply(input string name, input link_pkg::reply_t exp,
			input link_pkg::reply_t act);
		checks++;
		if (act !== exp) begin
			$display("** Error %s: expected valid=%0b error=%0b data=%h, actual valid=%0b error=%0b data=%h",
				name, exp.valid, exp.error, exp.data, act.valid, act.error, act.data);
			value_errs++;
		end
	endtask

	task automatic check_illegal(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			$display("** Error %s: expected illegal_reg_num=%0b, actual illegal_reg_num=%0b",
				name, exp, act);
			value_errs++;
		end
	endtask

	task automatic pop_expected();
		void'(exp_q.pop_front());
		void'(due_q.pop_front());
		void'(name_q.pop_front());
	endtask

	// reply checker, runs on the falling edge where outputs are settled
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (!reset) begin
			if (tx.valid) begin
				if (exp_q.size() == 0) begin
					$display("reply in cycle %0d with no read or bad opcode pending", cyc);
					other_errs++;
				end else begin
					check_reply(name_q[0], exp_q[0], tx);
					if (cyc != due_q[0]) begin
						$display("reply for %s came in cycle %0d instead of cycle %0d",
							name_q[0], cyc, due_q[0]);
						other_errs++;
					end
					pop_expected();
				end
			end else if (exp_q.size() > 0 && due_q[0] < cyc) begin
				$display("no reply in cycle %0d for %s", due_q[0], name_q[0]);
				other_errs++;
				pop_expected();
			end
		end
	end

	task automatic send_word(input logic [31:0] word, input string name);
		link_pkg::reply_t exp;
		@(posedge clk);
		rx_data <= word;
		rx_valid <= 1'b1;
		exp = predict_reply(word);
		if (exp.valid) begin
			exp_q.push_back(exp);
			due_q.push_back(cyc + 4); // header cycle is cyc + 1, reply 3 later
			name_q.push_back(name);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			rx_valid <= 1'b0;
			rx_data <= rnd(); // junk, must be ignored
		end
	endtask

	task automatic wait_replies();
		int n;
		n = 0;
		idle(1);
		while (exp_q.size() > 0 && n < 10) begin
			idle(1);
			n++;
		end
		if (exp_q.size() > 0) begin
			$display("no reply within 10 cycles for %s", name_q[0]);
			other_errs++;
			exp_q.delete();
			due_q.delete();
			name_q.delete();
		end
	endtask

	task automatic select_reg(input logic [31:0] num, input string name);
		send_word(header_word(link_pkg::OP_SELECT), name);
		send_word(num, name);
	endtask

	task automatic write_reg(input logic [31:0] data, input string name);
		send_word(header_word(link_pkg::OP_WRITE), name);
		send_word(data, name);
	endtask

	task automatic read_reg(input string name);
		send_word(header_word(link_pkg::OP_READ), name);
	endtask

	task automatic settle_and_check_illegal(input string name);
		idle(3);
		@(negedge clk);
		check_illegal(name, model_illegal(), illegal_reg_num);
	endtask

	initial begin
		logic [31:0] num;
		reset <= 1'b1;
		rx_data <= '0;
		rx_valid <= 1'b0;
		seed = 32'h2d1e_cac5;
		for (int i = 0; i < regfile_pkg::NUM_REGS; i++)
			model_regs[i] = '0;
		model_num = '0;
		model_pend = link_pkg::OP_NOP;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// everything reads back as zero after reset
		@(negedge clk);
		check_illegal("after reset", 1'b0, illegal_reg_num);
		for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
			select_reg(i, "select after reset");
			read_reg($sformatf("reset read of register %0d", i));
		end
		wait_replies();

		// write and read each register, then read all again in reverse
		for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
			select_reg(i, "select for write");
			write_reg(rnd(), "write");
			read_reg($sformatf("read of register %0d", i));
		end
		for (int i = regfile_pkg::NUM_REGS - 1; i >= 0; i--) begin
			select_reg(i, "select for reread");
			read_reg($sformatf("reread of register %0d", i));
		end
		wait_replies();

		// illegal numbers block writes and give error replies
		for (int b = 4; b < 32; b += 9) begin
			num = (rnd() & 32'hf) | (32'h1 << b);
			select_reg(num, "illegal select");
			settle_and_check_illegal($sformatf("illegal number %h", num));
			write_reg(rnd(), "write to illegal number");
			read_reg($sformatf("read of illegal number %h", num));
			wait_replies();
			select_reg(num & 32'hf, "legal reselect");
			settle_and_check_illegal($sformatf("legal number %0d", num & 32'hf));
			read_reg($sformatf("read after blocked write, register %0d", num & 32'hf));
			wait_replies();
		end

		// unknown opcodes, each followed by a normal command
		for (int op = 4; op < 16; op++) begin
			send_word(header_word(op[3:0]), $sformatf("bad opcode %0d", op));
			select_reg(op - 4, "select after bad opcode");
			read_reg($sformatf("read after bad opcode %0d", op));
		end
		wait_replies();

		// headers in consecutive cycles, nops in between
		select_reg(5, "select for burst");
		write_reg(rnd(), "write for burst");
		read_reg("burst read 1");
		read_reg("burst read 2");
		send_word(header_word(4'd9), "burst bad opcode 9");
		send_word(header_word(link_pkg::OP_NOP), "burst nop");
		read_reg("burst read 3");
		send_word(header_word(link_pkg::OP_NOP), "burst nop");
		send_word(header_word(4'd15), "burst bad opcode 15");
		read_reg("burst read 4");
		wait_replies();
		idle(5);

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: source/link_decoder.sv
`timescale 1ns/1ps

module link_decoder (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [link_pkg::WORD_W-1:0] rx_data,
	input  logic                        rx_valid,
	output regfile_pkg::reg_ctl_t       reg_ctl,
	output logic                        bad_op
);

	typedef enum logic {
		ST_HDR,     // next word is a header
		ST_PAYLOAD  // next word belongs to pend_op
	} state_t;

	state_t state;
	link_pkg::op_t pend_op; // select or write waiting for its payload
	link_pkg::link_word_u word;

	logic num_le_q;
	logic wr_en_q;
	logic rd_en_q;
	logic bad_op_q;
	logic [regfile_pkg::REG_W-1:0] data_q;

	assign word = rx_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_HDR;
			pend_op <= link_pkg::OP_NOP;
			num_le_q <= 1'b0;
			wr_en_q <= 1'b0;
			rd_en_q <= 1'b0;
			bad_op_q <= 1'b0;
		end else begin
			// strobes last one cycle
			num_le_q <= 1'b0;
			wr_en_q <= 1'b0;
			rd_en_q <= 1'b0;
			bad_op_q <= 1'b0;
			if (rx_valid) begin
				case (state)
					ST_HDR: begin
						case (word.hdr.op)
							link_pkg::OP_NOP: begin
							end
							link_pkg::OP_SELECT, link_pkg::OP_WRITE: begin
								pend_op <= word.hdr.op;
								state <= ST_PAYLOAD;
							end
							link_pkg::OP_READ: rd_en_q <= 1'b1;
							default: bad_op_q <= 1'b1; // unknown opcode
						endcase
					end
					ST_PAYLOAD: begin
						if (pend_op == link_pkg::OP_SELECT)
							num_le_q <= 1'b1;
						else
							wr_en_q <= 1'b1;
						state <= ST_HDR;
					end
					default: state <= ST_HDR;
				endcase
			end
		end
	end

	// payload word, only meaningful with num_le or wr_en
	always_ff @(posedge clk) begin
		if (rx_valid && state == ST_PAYLOAD)
			data_q <= word.raw;
	end

	assign reg_ctl = '{reg_num_le: num_le_q, wr_en: wr_en_q, rd_en: rd_en_q, data: data_q};
	assign bad_op = bad_op_q;

	// the register block relies on seeing one command per cycle
	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		$onehot0({reg_ctl.reg_num_le, reg_ctl.wr_en, reg_ctl.rd_en}));

endmodule

// File: source/link_pkg.sv
package link_pkg;

	localparam int WORD_W = 32; // one word on the master link
	localparam int OP_W = 4;    // opcode field at the top of a header

	// opcodes carried in the top nibble of a header word
	typedef enum logic [OP_W-1:0] {
		OP_NOP    = 4'd0,
		OP_SELECT = 4'd1, // payload is the register number
		OP_WRITE  = 4'd2, // payload is the write data
		OP_READ   = 4'd3  // no payload
	} op_t;
	// any other opcode value is answered with an error reply

	// header layout
	typedef struct packed {
		op_t                   op;
		logic [WORD_W-OP_W-1:0] rsvd; // ignored
	} cmd_hdr_t;

	// the same incoming word read as a header or as a payload,
	// depending on where the decoder is in the command
	typedef union packed {
		cmd_hdr_t          hdr;
		logic [WORD_W-1:0] raw;
	} link_word_u;

	// outgoing reply word, one per read or bad opcode
	typedef struct packed {
		logic              valid; // single cycle strobe
		logic              error; // illegal register number or bad opcode
		logic [WORD_W-1:0] data;  // zero when error is set
	} reply_t;

endpackage

// File: source/regfile_pkg.sv
package regfile_pkg;

	localparam int NUM_REGS = 16;
	localparam int REG_W = 32;
	localparam int IDX_W = 4; // index bits, everything above must be zero

	// strobes from the decoder, at most one high per cycle
	typedef struct packed {
		logic             reg_num_le; // load register number from data
		logic             wr_en;      // write data to selected register
		logic             rd_en;      // read selected register
		logic [REG_W-1:0] data;
	} reg_ctl_t;

	// registered read-back, one cycle after rd_en
	typedef struct packed {
		logic             valid;
		logic             illegal; // number was illegal when the read happened
		logic [REG_W-1:0] data;
	} rdbk_t;

endpackage

// File: source/register_block.sv
`timescale 1ns/1ps

module register_block (
	input  logic                  clk,
	input  logic                  reset,
	input  regfile_pkg::reg_ctl_t reg_ctl,
	output regfile_pkg::rdbk_t    rdbk,
	output logic                  illegal_reg_num
);

	// full 32-bit number as sent, only the low bits index the array
	logic [regfile_pkg::REG_W-1:0] reg_num;
	logic [regfile_pkg::IDX_W-1:0] idx;

	logic [regfile_pkg::REG_W-1:0] regs [regfile_pkg::NUM_REGS];

	logic rdbk_valid;
	logic rdbk_illegal;
	logic [regfile_pkg::REG_W-1:0] rdbk_data;

	always_ff @(posedge clk) begin
		if (reset)
			reg_num <= '0;
		else if (reg_ctl.reg_num_le)
			reg_num <= reg_ctl.data;
	end

	assign idx = reg_num[regfile_pkg::IDX_W-1:0];
	assign illegal_reg_num = |reg_num[regfile_pkg::REG_W-1:regfile_pkg::IDX_W];

	// writes are dropped while the number is out of range
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regfile_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (reg_ctl.wr_en && !illegal_reg_num) begin
			regs[idx] <= reg_ctl.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			rdbk_valid <= 1'b0;
		else
			rdbk_valid <= reg_ctl.rd_en;
	end

	always_ff @(posedge clk) begin
		if (reg_ctl.rd_en) begin
			rdbk_illegal <= illegal_reg_num;
			rdbk_data <= illegal_reg_num ? '0 : regs[idx]; // zero on bad number
		end
	end

	assign rdbk = '{valid: rdbk_valid, illegal: rdbk_illegal, data: rdbk_data};

	// read-back latency is fixed at one cycle, the reply timing depends on it
	a_rdbk_latency: assert property (@(posedge clk) disable iff (reset)
		rdbk.valid == $past(reg_ctl.rd_en));

endmodule

// File: source/register_link.sv
`timescale 1ns/1ps

module register_link (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [link_pkg::WORD_W-1:0] rx_data,  // word from the master
	input  logic                        rx_valid,
	output link_pkg::reply_t            tx,       // reply to the master
	output logic                        illegal_reg_num
);

	regfile_pkg::reg_ctl_t reg_ctl;
	regfile_pkg::rdbk_t rdbk;
	logic bad_op;

	// header and payload decode
	link_decoder u_decoder (
		.clk     (clk),
		.reset   (reset),
		.rx_data (rx_data),
		.rx_valid(rx_valid),
		.reg_ctl (reg_ctl),
		.bad_op  (bad_op)
	);

	register_block u_regs (
		.clk            (clk),
		.reset          (reset),
		.reg_ctl        (reg_ctl),
		.rdbk           (rdbk),
		.illegal_reg_num(illegal_reg_num)
	);

	// one reply per read or bad opcode, three cycles after the header
	reply_builder u_reply (
		.clk   (clk),
		.reset (reset),
		.rdbk  (rdbk),
		.bad_op(bad_op),
		.tx    (tx)
	);

endmodule

// File: source/reply_builder.sv
`timescale 1ns/1ps

module reply_builder (
	input  logic               clk,
	input  logic               reset,
	input  regfile_pkg::rdbk_t rdbk,
	input  logic               bad_op,
	output link_pkg::reply_t   tx
);

	logic bad_op_d; // lines bad_op up with rdbk.valid
	logic tx_valid;
	logic tx_error;
	logic [link_pkg::WORD_W-1:0] tx_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			bad_op_d <= 1'b0;
			tx_valid <= 1'b0;
			tx_error <= 1'b0;
		end else begin
			bad_op_d <= bad_op;
			tx_valid <= rdbk.valid | bad_op_d;
			if (rdbk.valid)
				tx_error <= rdbk.illegal;
			else
				tx_error <= bad_op_d;
		end
	end

	always_ff @(posedge clk) begin
		if (rdbk.valid)
			tx_data <= rdbk.data; // already zero for an illegal number
		else if (bad_op_d)
			tx_data <= '0; // bad opcode carries no data
	end

	assign tx = '{valid: tx_valid, error: tx_error, data: tx_data};

	a_err_no_data: assert property (@(posedge clk) disable iff (reset)
		tx.error |-> tx.data == '0);

	// decoder issues one command per cycle, so these two never meet
	a_no_collision: assert property (@(posedge clk) disable iff (reset)
		!(rdbk.valid && bad_op_d));

endmodule
